//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(wildcard src/*.sv) $(wildcard tb/*.sv) $(wildcard include/*.svh)
	$(VERILATOR) $(VFLAGS) $(EXTRA) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
+incdir+include
src/rv_pkg.sv
src/control_unit.sv
src/imm_gen.sv
src/reg_file.sv
src/alu.sv
src/lsu_apb.sv
src/rv_core.sv
tb/tb_mem_model.sv
tb/tb_rv_core.sv

//--- include/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define XLEN        32
`define RESET_PC    32'h0000_0000

// Instruction field widths
`define OPCODE_W    7
`define FUNCT3_W    3
`define FUNCT7_W    7
`define REG_ADDR_W  5

`define OP_IMM      7'b0010011
`define OP_R3       7'b0110011
`define OP_LD       7'b0000011
`define OP_ST       7'b0100011
`define OP_BR       7'b1100011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111

`define ADD_SUB     3'b000
`define SLL         3'b001
`define SLT         3'b010
`define SLTU        3'b011
`define XOR         3'b100
`define SRL_SRA     3'b101
`define OR          3'b110
`define AND         3'b111

`define LB          3'b000
`define LH          3'b001
`define LW          3'b010
`define LBU         3'b100
`define LHU         3'b101

`define SB          3'b000
`define SH          3'b001
`define SW          3'b010

`define BEQ         3'b000
`define BNE         3'b001
`define BLT         3'b100
`define BGE         3'b101
`define BLTU        3'b110
`define BGEU        3'b111

`endif

//--- src/alu.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module alu (
    input  logic [`XLEN-1:0]     a,
    input  logic [`XLEN-1:0]     b,
    input  rv_pkg::alu_op_e      op,
    input  logic [`FUNCT3_W-1:0] funct3,
    output logic [`XLEN-1:0]     result,
    output logic                 branch_taken
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       eq;
    logic       lt;
    logic       ltu;

    assign shamt = b[4:0];
    assign eq    = (a == b);
    assign lt    = ($signed(a) < $signed(b));
    assign ltu   = (a < b);

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_sll:    result = a << shamt;
            alu_slt:    result = {{(`XLEN-1){1'b0}}, lt};
            alu_sltu:   result = {{(`XLEN-1){1'b0}}, ltu};
            alu_xor:    result = a ^ b;
            alu_srl:    result = a >> shamt;
            alu_sra:    result = $signed(a) >>> shamt;
            alu_or:     result = a | b;
            alu_and:    result = a & b;
            alu_pass_b: result = b;             // LUI
            default:    result = a + b;
        endcase
    end

    // Only consulted when the decoder flags a branch
    always_comb begin
        case (funct3)
            `BEQ:    branch_taken = eq;
            `BNE:    branch_taken = !eq;
            `BLT:    branch_taken = lt;
            `BGE:    branch_taken = !lt;
            `BLTU:   branch_taken = ltu;
            `BGEU:   branch_taken = !ltu;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

//--- src/control_unit.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module control_unit (
    input  rv_pkg::instr_u    instr,
    output logic              reg_write,
    output logic              alu_src_pc,    // ALU a from PC instead of rs1
    output logic              alu_src_imm,   // ALU b from immediate instead of rs2
    output rv_pkg::alu_op_e   alu_op,
    output rv_pkg::imm_fmt_e  imm_fmt,
    output logic              is_branch,
    output logic              is_jal,
    output logic              is_jalr,
    output logic              mem_read,
    output logic              mem_write,
    output rv_pkg::mem_size_e mem_size,
    output logic              mem_unsigned,
    output rv_pkg::wb_sel_e   wb_sel
);
    import rv_pkg::*;

    logic [`FUNCT3_W-1:0] funct3;
    logic                 alt;

    assign funct3 = instr.r_fmt.funct3;
    assign alt    = instr.r_fmt.funct7[5];  // Selects sub and sra

    // Shared by register and immediate arithmetic; there is no subtract-immediate
    function automatic alu_op_e decode_arith(input logic [`FUNCT3_W-1:0] f3,
                                             input logic alt_bit, input logic reg_op);
        case (f3)
            `ADD_SUB: decode_arith = (alt_bit && reg_op) ? alu_sub : alu_add;
            `SLL:     decode_arith = alu_sll;
            `SLT:     decode_arith = alu_slt;
            `SLTU:    decode_arith = alu_sltu;
            `XOR:     decode_arith = alu_xor;
            `SRL_SRA: decode_arith = alt_bit ? alu_sra : alu_srl;
            `OR:      decode_arith = alu_or;
            default:  decode_arith = alu_and;
        endcase
    endfunction

    always_comb begin
        reg_write    = 1'b0;
        alu_src_pc   = 1'b0;
        alu_src_imm  = 1'b0;
        alu_op       = alu_add;
        imm_fmt      = imm_i;
        is_branch    = 1'b0;
        is_jal       = 1'b0;
        is_jalr      = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_size     = size_word;
        mem_unsigned = 1'b0;
        wb_sel       = wb_alu;

        case (instr.r_fmt.opcode)
            `OP_IMM: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = decode_arith(funct3, alt, 1'b0);
            end
            `OP_R3: begin
                reg_write = 1'b1;
                alu_op    = decode_arith(funct3, alt, 1'b1);
            end
            `OP_LD: begin
                reg_write    = 1'b1;
                alu_src_imm  = 1'b1;        // Address is rs1 + imm
                mem_read     = 1'b1;
                mem_unsigned = (funct3 == `LBU) || (funct3 == `LHU);
                wb_sel       = wb_mem;
                case (funct3)
                    `LB, `LBU: mem_size = size_byte;
                    `LH, `LHU: mem_size = size_half;
                    default:   mem_size = size_word;
                endcase
            end
            `OP_ST: begin
                alu_src_imm = 1'b1;
                imm_fmt     = imm_s;
                mem_write   = 1'b1;
                case (funct3)
                    `SB:     mem_size = size_byte;
                    `SH:     mem_size = size_half;
                    default: mem_size = size_word;
                endcase
            end
            `OP_BR: begin
                is_branch = 1'b1;           // ALU compares rs1 with rs2
                imm_fmt   = imm_b;
            end
            `OP_LUI: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = alu_pass_b;
                imm_fmt     = imm_u;
            end
            `OP_AUIPC: begin
                reg_write   = 1'b1;
                alu_src_pc  = 1'b1;
                alu_src_imm = 1'b1;
                imm_fmt     = imm_u;
            end
            `OP_JAL: begin
                reg_write = 1'b1;
                is_jal    = 1'b1;
                imm_fmt   = imm_j;
                wb_sel    = wb_pc_plus4;    // Link address
            end
            `OP_JALR: begin
                reg_write = 1'b1;
                is_jalr   = 1'b1;
                wb_sel    = wb_pc_plus4;
            end
            default: ;                      // Unknown opcode retires as a no-op
        endcase
    end

endmodule

//--- src/imm_gen.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module imm_gen (
    input  rv_pkg::instr_u   instr,
    input  rv_pkg::imm_fmt_e imm_fmt,
    output logic [`XLEN-1:0] imm
);
    import rv_pkg::*;

    always_comb begin
        case (imm_fmt)
            imm_i: imm = {{(`XLEN-12){instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            imm_s: imm = {{(`XLEN-12){instr.s_fmt.imm_11_5[6]}},
                          instr.s_fmt.imm_11_5, instr.s_fmt.imm_4_0};
            imm_b: imm = {{(`XLEN-12){instr.b_fmt.imm_12}},
                          instr.b_fmt.imm_11,
                          instr.b_fmt.imm_10_5,
                          instr.b_fmt.imm_4_1,
                          1'b0};            // Branch offsets are halfword multiples
            imm_u: imm = {instr.u_fmt.imm_31_12, 12'h000};
            imm_j: imm = {{(`XLEN-20){instr.j_fmt.imm_20}},
                          instr.j_fmt.imm_19_12,
                          instr.j_fmt.imm_11,
                          instr.j_fmt.imm_10_1,
                          1'b0};
            default: imm = '0;
        endcase
    end

endmodule

//--- src/lsu_apb.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module lsu_apb (
    input  logic                clk,
    input  logic                reset,
    input  logic                mem_read,
    input  logic                mem_write,
    input  rv_pkg::mem_size_e   mem_size,
    input  logic                mem_unsigned,
    input  logic [`XLEN-1:0]    addr,
    input  logic [`XLEN-1:0]    store_data,
    output logic [`XLEN-1:0]    load_data,
    output logic                stall,
    output logic [`XLEN-1:0]    paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [`XLEN-1:0]    pwdata,
    output logic [`XLEN/8-1:0]  pstrb,
    input  logic [`XLEN-1:0]    prdata,
    input  logic                pready
);
    import rv_pkg::*;

    logic             in_access;    // Low is idle or setup, high is access
    logic [1:0]       offset;
    logic [`XLEN-1:0] lane_data;

    assign offset = addr[1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            in_access <= 1'b0;
        end else if (!in_access) begin
            in_access <= mem_read || mem_write;
        end else if (pready) begin
            in_access <= 1'b0;
        end
    end

    // Setup comes straight from the decoded instruction, which holds while stalled
    assign psel    = in_access || ((mem_read || mem_write) && !reset);
    assign penable = in_access;
    assign stall   = psel && !(penable && pready);

    assign paddr  = {addr[`XLEN-1:2], 2'b00};
    assign pwrite = mem_write;
    assign pwdata = store_data << {offset, 3'b000};

    always_comb begin
        case (mem_size)
            size_byte: pstrb = 4'b0001 << offset;
            size_half: pstrb = 4'b0011 << offset;
            default:   pstrb = 4'b1111;
        endcase
        if (!mem_write) begin
            pstrb = '0;                 // No strobes on reads
        end
    end

    assign lane_data = prdata >> {offset, 3'b000};

    always_comb begin
        case (mem_size)
            size_byte: load_data = {{(`XLEN-8){!mem_unsigned && lane_data[7]}},
                                    lane_data[7:0]};
            size_half: load_data = {{(`XLEN-16){!mem_unsigned && lane_data[15]}},
                                    lane_data[15:0]};
            default:   load_data = prdata;
        endcase
    end

    // A wait state keeps the whole access phase frozen
    property p_apb_hold;
        @(posedge clk) disable iff (reset)
        (penable && !pready) |=> psel && penable && $stable({paddr, pwrite, pwdata, pstrb});
    endproperty
    a_apb_hold: assert property (p_apb_hold)
        else $error("lsu_apb: APB outputs changed during a wait state");

endmodule

//--- src/reg_file.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       rs1_data,
    output logic [`XLEN-1:0]       rs2_data,
    input  logic [`REG_ADDR_W-1:0] rd_addr,
    input  logic [`XLEN-1:0]       rd_data,
    input  logic                   rd_we
);

    logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && (rd_addr != '0)) begin
            regs[rd_addr] <= rd_data;       // x0 never leaves zero
        end
    end

    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

//--- src/rv_core.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_core (
    input  logic                clk,
    input  logic                reset,
    output logic [`XLEN-1:0]    imem_addr,
    input  logic [`XLEN-1:0]    imem_data,
    output logic [`XLEN-1:0]    paddr,
    output logic                psel,
    output logic                penable,
    output logic                pwrite,
    output logic [`XLEN-1:0]    pwdata,
    output logic [`XLEN/8-1:0]  pstrb,
    input  logic [`XLEN-1:0]    prdata,
    input  logic                pready
);
    import rv_pkg::*;

    instr_u           instr;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] jalr_sum;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] alu_a;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] wb_data;
    logic             branch_taken;
    logic             stall;

    logic      reg_write;
    logic      alu_src_pc;
    logic      alu_src_imm;
    alu_op_e   alu_op;
    imm_fmt_e  imm_fmt;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      mem_read;
    logic      mem_write;
    mem_size_e mem_size;
    logic      mem_unsigned;
    wb_sel_e   wb_sel;

    assign instr     = imem_data;
    assign imem_addr = pc;
    assign pc_plus4  = pc + `XLEN'd4;
    assign jalr_sum  = rs1_data + imm;

    always_comb begin
        if (is_jalr) begin
            pc_next = {jalr_sum[`XLEN-1:1], 1'b0};
        end else if (is_jal || (is_branch && branch_taken)) begin
            pc_next = pc + imm;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (!stall) begin
            pc <= pc_next;                  // Frozen through APB wait states
        end
    end

    assign alu_a = alu_src_pc  ? pc  : rs1_data;
    assign alu_b = alu_src_imm ? imm : rs2_data;

    always_comb begin
        case (wb_sel)
            wb_mem:      wb_data = load_data;
            wb_pc_plus4: wb_data = pc_plus4;
            default:     wb_data = alu_result;
        endcase
    end

    control_unit u_control (
        .instr       (instr),
        .reg_write   (reg_write),
        .alu_src_pc  (alu_src_pc),
        .alu_src_imm (alu_src_imm),
        .alu_op      (alu_op),
        .imm_fmt     (imm_fmt),
        .is_branch   (is_branch),
        .is_jal      (is_jal),
        .is_jalr     (is_jalr),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_size    (mem_size),
        .mem_unsigned(mem_unsigned),
        .wb_sel      (wb_sel)
    );

    imm_gen u_imm_gen (
        .instr  (instr),
        .imm_fmt(imm_fmt),
        .imm    (imm)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .reset   (reset),
        .rs1_addr(instr.r_fmt.rs1),
        .rs2_addr(instr.r_fmt.rs2),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .rd_addr (instr.r_fmt.rd),
        .rd_data (wb_data),
        .rd_we   (reg_write && !stall)      // Loads write on the last APB edge
    );

    alu u_alu (
        .a           (alu_a),
        .b           (alu_b),
        .op          (alu_op),
        .funct3      (instr.r_fmt.funct3),
        .result      (alu_result),
        .branch_taken(branch_taken)
    );

    lsu_apb u_lsu (
        .clk         (clk),
        .reset       (reset),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_size    (mem_size),
        .mem_unsigned(mem_unsigned),
        .addr        (alu_result),
        .store_data  (rs2_data),
        .load_data   (load_data),
        .stall       (stall),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .pstrb       (pstrb),
        .prdata      (prdata),
        .pready      (pready)
    );

endmodule

//--- src/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

    typedef struct packed {
        logic [`FUNCT7_W-1:0]   funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]            imm_11_0;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]             imm_11_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [4:0]             imm_4_0;
        logic [`OPCODE_W-1:0]   opcode;
    } s_fmt_t;

    typedef struct packed {
        logic                   imm_12;
        logic [5:0]             imm_10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [3:0]             imm_4_1;
        logic                   imm_11;
        logic [`OPCODE_W-1:0]   opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0]            imm_31_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } u_fmt_t;

    typedef struct packed {
        logic                   imm_20;
        logic [9:0]             imm_10_1;
        logic                   imm_11;
        logic [7:0]             imm_19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`OPCODE_W-1:0]   opcode;
    } j_fmt_t;

    // One fetched word, viewed in every base format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc_plus4} wb_sel_e;

    typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

    typedef enum logic [2:0] {imm_i, imm_s, imm_b, imm_u, imm_j} imm_fmt_e;

endpackage

//--- tb/tb_mem_model.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module tb_mem_model (
    input  logic             clk,
    input  logic             reset,
    input  logic [`XLEN-1:0] imem_addr,
    output logic [`XLEN-1:0] imem_data,
    input  logic [`XLEN-1:0] paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [`XLEN-1:0] pwdata,
    input  logic [3:0]       pstrb,
    output logic [`XLEN-1:0] prdata,
    output logic             pready,
    input  logic [1:0]       wait_states     // Wait states for the next access
);

    logic [`XLEN-1:0] rom [256];              // Filled by the testbench
    logic [`XLEN-1:0] ram [256];
    logic [1:0]       wait_cnt;

    initial begin
        for (int i = 0; i < 256; i++) begin
            ram[i] = (32'(i) * 32'h0101_0101) ^ 32'hc3a5_0f00;
        end
    end

    assign imem_data = rom[imem_addr[9:2]];    // Combinational fetch
    assign prdata    = ram[paddr[9:2]];
    assign pready    = (wait_cnt == 2'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wait_cnt <= 2'd0;
        end else if (psel && !penable) begin
            wait_cnt <= wait_states;           // Latched in the setup phase
        end else if (psel && penable && (wait_cnt != 2'd0)) begin
            wait_cnt <= wait_cnt - 2'd1;
        end
    end

    always @(posedge clk) begin
        if (!reset && psel && penable && pready && pwrite) begin
            for (int b = 0; b < 4; b++) begin
                if (pstrb[b]) begin
                    ram[paddr[9:2]][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- tb/tb_rv_core.sv
`timescale 1ns/100ps
`include "rv_defines.svh"

module tb_rv_core;
    localparam int TIMEOUT = 20000;

    logic clk = 1'b0;
    logic reset;
    logic [31:0] imem_addr;
    logic [31:0] imem_data;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic [3:0]  pstrb;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic        pready;
    logic [1:0]  wait_states;

    logic [31:0] lfsr = 32'h5a38_b12f;
    logic [31:0] rnd;
    logic [31:0] prog [$];
    logic [31:0] xr [32];                    // Expected register contents
    logic [7:0]  dbytes [1024];              // Expected data memory bytes
    logic [67:0] exp_q [$];                  // {paddr, pwdata, pstrb}
    string       exp_name [$];
    string       test_name;
    logic [67:0] exp_entry;
    logic [67:0] got_entry;                  // Observed write, disabled lanes cleared
    string       exp_tag;
    logic [11:0] slot;
    int          rst_seen = 0;
    logic        first_run = 1'b0;

    always #10 clk = ~clk;

    rv_core uut (.clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
                 .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
                 .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready));

    tb_mem_model u_mem (.clk(clk), .reset(reset), .imem_addr(imem_addr), .imem_data(imem_data),
                        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
                        .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
                        .wait_states(wait_states));

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            `ADD_SUB: return alt ? a - b : a + b;
            `SLL:     return a << b[4:0];
            `SLT:     return {31'd0, $signed(a) < $signed(b)};
            `SLTU:    return {31'd0, a < b};
            `XOR:     return a ^ b;
            `SRL_SRA: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            `OR:      return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            `BEQ:    return a == b;
            `BNE:    return a != b;
            `BLT:    return $signed(a) < $signed(b);
            `BGE:    return $signed(a) >= $signed(b);
            `BLTU:   return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] strobe_mask(input logic [3:0] s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    function automatic logic [31:0] next_pc();
        return 32'(prog.size() * 4);
    endfunction

    task automatic set_reg(input logic [4:0] rd, input logic [31:0] v);
        if (rd != 5'd0) xr[rd] = v;
    endtask

    task automatic op_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
        prog.push_back({alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, `OP_R3});
        set_reg(rd, ref_alu(f3, alt, xr[rs1], xr[rs2]));
    endtask

    task automatic op_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
        prog.push_back({imm, rs1, f3, rd, `OP_IMM});
        set_reg(rd, ref_alu(f3, (f3 == `SRL_SRA) && imm[10], xr[rs1], {{20{imm[11]}}, imm}));
    endtask

    task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;                    // Compensates the sign of the low part
        prog.push_back({hi[31:12], rd, `OP_LUI});
        set_reg(rd, {hi[31:12], 12'h000});
        op_i(`ADD_SUB, rd, rd, v[11:0]);
    endtask

    task automatic store(input logic [2:0] f3, input logic [4:0] rs2, input logic [11:0] off);
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        int          src;
        addr = xr[1] + {{20{off[11]}}, off};
        strb = (f3 == `SB) ? 4'b0001 << addr[1:0] :
               (f3 == `SH) ? 4'b0011 << addr[1:0] : 4'b1111;
        data = '0;
        prog.push_back({off[11:5], rs2, 5'd1, f3, off[4:0], `OP_ST});
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                src = b - int'(addr[1:0]);   // Low bytes of rs2 fill the enabled lanes
                data[8*b +: 8] = xr[rs2][8*src +: 8];
                dbytes[{addr[9:2], 2'(b)}] = data[8*b +: 8];
            end
        end
        exp_q.push_back({addr[31:2], 2'b00, data, strb});
        exp_name.push_back(test_name);
    endtask

    task automatic keep(input logic [4:0] rd);
        store(`SW, rd, slot);
        slot = slot + 12'd4;
    endtask

    task automatic load(input logic [2:0] f3, input logic [4:0] rd, input logic [11:0] off);
        logic [31:0] addr;
        logic [31:0] lane;
        addr = xr[1] + {{20{off[11]}}, off};
        lane = {dbytes[{addr[9:2], 2'd3}], dbytes[{addr[9:2], 2'd2}],
                dbytes[{addr[9:2], 2'd1}], dbytes[{addr[9:2], 2'd0}]} >> {addr[1:0], 3'b000};
        prog.push_back({off, 5'd1, f3, rd, `OP_LD});
        case (f3)
            `LB:     set_reg(rd, {{24{lane[7]}}, lane[7:0]});
            `LH:     set_reg(rd, {{16{lane[15]}}, lane[15:0]});
            `LBU:    set_reg(rd, {24'd0, lane[7:0]});
            `LHU:    set_reg(rd, {16'd0, lane[15:0]});
            default: set_reg(rd, lane);
        endcase
        keep(rd);
    endtask

    task automatic marker();
        prog.push_back({7'h1f, 5'd0, 5'd0, `SW, 5'h10, `OP_ST});  // SW x0 to 0x3f0
    endtask

    // The path that must not run always holds the marker store
    task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
        prog.push_back({1'b0, 6'd0, rs2, rs1, f3, 4'b0100, 1'b0, `OP_BR});  // Offset +8
        if (!ref_branch(f3, xr[rs1], xr[rs2])) prog.push_back(enc_jal(21'd8, 5'd0));
        marker();
    endtask

    initial begin
        logic [2:0]  br_f3 [6];
        logic [31:0] p;
        reset = 1'b1;
        wait_states = 2'd0;
        br_f3 = '{`BEQ, `BNE, `BLT, `BGE, `BLTU, `BGEU};
        for (int i = 0; i < 32; i++) xr[i] = '0;
        test_name = "operands";
        slot = 12'h040;
        op_i(`ADD_SUB, 5'd1, 5'd0, 12'h200);                    // Store base in x1
        random_bits(32, rnd);
        load_const(5'd2, rnd);
        random_bits(32, rnd);
        load_const(5'd3, rnd);
        test_name = "r_type";
        for (int f = 0; f < 10; f++) begin
            op_r(f < 8 ? 3'(f) : (f == 8 ? `ADD_SUB : `SRL_SRA), f >= 8, 5'd5, 5'd2, 5'd3);
            keep(5'd5);
        end
        test_name = "op_imm";
        for (int f = 0; f < 9; f++) begin
            random_bits(12, rnd);
            if (f == 1 || f >= 5 && f != 6 && f != 7) rnd[11:5] = (f == 8) ? 7'h20 : 7'h00;
            op_i(f < 8 ? 3'(f) : `SRL_SRA, 5'd5, 5'd2, rnd[11:0]);
            keep(5'd5);
        end
        test_name = "lui_auipc";
        random_bits(20, rnd);
        prog.push_back({rnd[19:0], 5'd6, `OP_LUI});
        set_reg(5'd6, {rnd[19:0], 12'h000});
        keep(5'd6);
        p = next_pc();
        prog.push_back({rnd[19:0], 5'd6, `OP_AUIPC});
        set_reg(5'd6, p + {rnd[19:0], 12'h000});
        keep(5'd6);
        test_name = "mem_size";
        store(`SW, 5'd2, 12'd0);
        store(`SB, 5'd3, 12'd1);
        store(`SH, 5'd3, 12'd2);
        store(`SB, 5'd2, 12'd3);
        load(`LB, 5'd5, 12'd1);
        load(`LB, 5'd5, 12'd3);
        load(`LH, 5'd5, 12'd0);
        load(`LH, 5'd5, 12'd2);
        load(`LBU, 5'd5, 12'd1);
        load(`LBU, 5'd5, 12'd3);
        load(`LHU, 5'd5, 12'd0);
        load(`LHU, 5'd5, 12'd2);
        load(`LW, 5'd5, 12'd0);
        test_name = "branch";
        for (int k = 0; k < 6; k++) begin
            branch(br_f3[k], 5'd2, 5'd3);
            branch(br_f3[k], 5'd3, 5'd2);
            branch(br_f3[k], 5'd2, 5'd2);
        end
        test_name = "jal";
        p = next_pc();
        prog.push_back(enc_jal(21'd8, 5'd7));
        set_reg(5'd7, p + 32'd4);
        marker();
        keep(5'd7);
        test_name = "jalr";
        p = next_pc();
        op_i(`ADD_SUB, 5'd8, 5'd0, 12'(p + 32'd12));
        prog.push_back({12'd1, 5'd8, 3'b000, 5'd9, `OP_JALR});    // Target bit 0 is cleared
        set_reg(5'd9, p + 32'd8);
        marker();
        keep(5'd9);
        prog.push_back(enc_jal(21'd0, 5'd0));                     // End of program loop
        for (int i = 0; i < 256; i++) begin
            u_mem.rom[i] = (i < prog.size()) ? prog[i] : 32'h0000_0013;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        begin
            int same;
            logic [31:0] prev;
            same = 0;
            prev = '1;
            for (int cyc = 0; cyc < TIMEOUT && same < 2; cyc++) begin
                @(negedge clk);
                same = (!psel && imem_addr == prev) ? same + 1 : 0;
                prev = imem_addr;
            end
            if (same < 2) begin
                stop_on_error("Timeout waiting for the end-of-program loop");
            end else if (exp_q.size() != 0) begin
                stop_on_error($sformatf("%0d expected stores never appeared", exp_q.size()));
            end else begin
                $display("PASS: all tests");
                $finish;
            end
        end
    end

    always @(posedge clk) begin
        random_bits(2, rnd);
        wait_states <= rnd[1:0];
        if (reset) rst_seen <= rst_seen + 1;
        first_run <= reset;
    end

    always @(negedge clk) begin
        if ((reset && rst_seen > 0) || (!reset && first_run)) begin
            assert (!psel && !penable)
                else stop_on_error("APB select or enable was active around reset");
            assert (imem_addr == `RESET_PC)
                else stop_on_error($sformatf("ERR reset expected %h actual %h", `RESET_PC,
                                             imem_addr));
        end
        if (!reset && psel && penable && pready && pwrite) begin
            if (exp_q.size() == 0) begin
                stop_on_error("APB write seen with no store left in the expected queue");
            end else begin
                exp_entry = exp_q.pop_front();
                exp_tag = exp_name.pop_front();
                got_entry = {paddr, pwdata & strobe_mask(exp_entry[3:0]), pstrb};
                assert (got_entry == exp_entry)
                    else stop_on_error($sformatf("ERR %s expected %h actual %h", exp_tag,
                                                 exp_entry, got_entry));
            end
        end
    end

    a_setup_first: assert property (@(posedge clk) disable iff (reset)
        $rose(penable) |-> $past(psel && !penable))
        else stop_on_error("APB access phase began without a setup phase");

    a_wait_stable: assert property (@(posedge clk) disable iff (reset)
        (penable && !pready) |=> penable && $stable({paddr, pwrite, pwdata, pstrb}))
        else stop_on_error("APB outputs changed while pready was low");

endmodule
